// File: all.f
common/rvPkg.sv
core/rvDecode.sv
core/rvExecute.sv
core/rvCore.sv
verilog/regFile.sv
verilog/instMem.sv
verilog/dataMem.sv
verilog/cpuSystem.sv
verification/cpuSystemAssert_assert.sv
verification/cpuSystemTb.sv

// File: common/rvPkg.sv
package rvPkg;

	localparam int XLEN = 32;
	// word address width of each memory
	localparam int MEM_AW = 10;
	localparam int MEM_WORDS = 1 << MEM_AW;
	// byte address width seen by the core
	localparam int PC_W = MEM_AW + 2;
	localparam int REG_AW = 5;
	localparam int NUM_REGS = 1 << REG_AW;

	// major opcodes kept from RV32I
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		SYSTEM = 7'b1110011
	} opcodeE;

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		SLT = 3'd5
	} aluOpE;

	// all zero means no-op
	typedef struct packed {
		logic regWrite;
		logic memWrite;
		logic memRead;
		logic useImm;
		logic isBranch;
		logic isJump;
		logic isHalt;
		aluOpE aluOp;
	} ctrlT;

	typedef struct packed {
		logic valid;
		logic [MEM_AW-1:0] addr;
		logic [XLEN-1:0] data;
	} progWriteT;

	typedef struct packed {
		logic wen;
		logic [MEM_AW-1:0] addr;
		logic [XLEN-1:0] wdata;
	} dMemReqT;

	typedef struct packed {
		logic we;
		logic [REG_AW-1:0] addr;
		logic [XLEN-1:0] data;
	} rfWriteT;

	// fetch/decode -> register read
	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		logic [PC_W-1:0] pcPlus4;
		logic [XLEN-1:0] imm;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
	} decStageT;

	// register read -> execute
	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		logic [PC_W-1:0] pcPlus4;
		logic [XLEN-1:0] imm;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		logic [XLEN-1:0] rd1;
		logic [XLEN-1:0] rd2;
	} exStageT;

	// execute -> memory/write-back
	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0] aluResult;
		logic [XLEN-1:0] storeData;
	} memStageT;

endpackage

// File: core/rvCore.sv
module rvCore (
	input logic CLK,
	input logic RSTn,

	// instruction memory
	output logic [rvPkg::PC_W-1:0] iMemAddr,
	input logic [rvPkg::XLEN-1:0] iMemData,

	// data memory
	output rvPkg::dMemReqT dMemReq,
	input logic [rvPkg::XLEN-1:0] dMemRdata,

	// register file
	output logic [rvPkg::REG_AW-1:0] rfRa1,
	output logic [rvPkg::REG_AW-1:0] rfRa2,
	input logic [rvPkg::XLEN-1:0] rfRd1,
	input logic [rvPkg::XLEN-1:0] rfRd2,
	output rvPkg::rfWriteT rfWrite,

	output logic halt,
	output logic [31:0] numInst
);

	logic [rvPkg::PC_W-1:0] pc;
	rvPkg::decStageT decStage;
	rvPkg::exStageT exStage;
	rvPkg::memStageT memStage;

	rvPkg::ctrlT decCtrl;
	logic [rvPkg::XLEN-1:0] decImm;
	logic [rvPkg::XLEN-1:0] aluResult;
	logic [rvPkg::XLEN-1:0] storeData;
	logic redirect;
	logic takeRedirect;
	logic [rvPkg::PC_W-1:0] target;
	logic retire;
	logic haltNow;
	logic freeze;

	// stage 1: fetch and decode
	assign iMemAddr = pc;

	rvDecode decode_i (
		.instr(iMemData),
		.ctrl(decCtrl),
		.imm(decImm)
	);

	// stage 2: register read
	assign rfRa1 = decStage.rs1;
	assign rfRa2 = decStage.rs2;

	// stage 3: execute
	rvExecute execute_i (
		.ctrl(exStage.ctrl),
		.pcPlus4(exStage.pcPlus4),
		.imm(exStage.imm),
		.rs1(exStage.rs1),
		.rs2(exStage.rs2),
		.rd1(exStage.rd1),
		.rd2(exStage.rd2),
		.wbFwd(rfWrite),
		.aluResult(aluResult),
		.storeData(storeData),
		.redirect(redirect),
		.target(target)
	);

	assign takeRedirect = exStage.valid & redirect;

	// stage 4: memory and write-back
	assign retire = memStage.valid & ~halt;
	assign haltNow = retire & memStage.ctrl.isHalt;
	// ebreak in stage 4 stops everything behind it
	assign freeze = halt | haltNow;

	assign dMemReq.wen = retire & memStage.ctrl.memWrite;
	assign dMemReq.addr = memStage.aluResult[rvPkg::MEM_AW+1:2];
	assign dMemReq.wdata = memStage.storeData;

	assign rfWrite.we = retire & memStage.ctrl.regWrite;
	assign rfWrite.addr = memStage.rd;
	assign rfWrite.data = memStage.ctrl.memRead ? dMemRdata : memStage.aluResult;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
			decStage.valid <= 1'b0;
			exStage.valid <= 1'b0;
			memStage.valid <= 1'b0;
		end else if (!freeze) begin
			pc <= takeRedirect ? target : pc + rvPkg::PC_W'(4);

			// two younger slots are dropped on a taken redirect
			decStage.valid <= ~takeRedirect;
			decStage.ctrl <= decCtrl;
			decStage.pcPlus4 <= pc + rvPkg::PC_W'(4);
			decStage.imm <= decImm;
			decStage.rd <= iMemData[11:7];
			decStage.rs1 <= iMemData[19:15];
			decStage.rs2 <= iMemData[24:20];

			exStage.valid <= decStage.valid & ~takeRedirect;
			exStage.ctrl <= decStage.ctrl;
			exStage.pcPlus4 <= decStage.pcPlus4;
			exStage.imm <= decStage.imm;
			exStage.rd <= decStage.rd;
			exStage.rs1 <= decStage.rs1;
			exStage.rs2 <= decStage.rs2;
			exStage.rd1 <= rfRd1;
			exStage.rd2 <= rfRd2;

			memStage.valid <= exStage.valid;
			memStage.ctrl <= exStage.ctrl;
			memStage.rd <= exStage.rd;
			memStage.aluResult <= aluResult;
			memStage.storeData <= storeData;
		end
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			halt <= 1'b0;
			numInst <= '0;
		end else begin
			if (haltNow) begin
				halt <= 1'b1;
			end
			// ebreak counts too
			if (retire) begin
				numInst <= numInst + 32'd1;
			end
		end
	end

endmodule

// File: core/rvDecode.sv
module rvDecode (
	input logic [rvPkg::XLEN-1:0] instr,
	output rvPkg::ctrlT ctrl,
	output logic [rvPkg::XLEN-1:0] imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [rvPkg::REG_AW-1:0] rd;
	logic [rvPkg::XLEN-1:0] immI;
	logic [rvPkg::XLEN-1:0] immS;
	logic [rvPkg::XLEN-1:0] immB;
	logic [rvPkg::XLEN-1:0] immJ;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rd = instr[11:7];

	// sign-extended immediates per format
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		ctrl = '0;
		imm = '0;
		case (opcode)
			rvPkg::OP: begin
				ctrl.regWrite = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: ctrl.aluOp = rvPkg::ADD;
					{7'b0100000, 3'b000}: ctrl.aluOp = rvPkg::SUB;
					{7'b0000000, 3'b111}: ctrl.aluOp = rvPkg::AND;
					{7'b0000000, 3'b110}: ctrl.aluOp = rvPkg::OR;
					{7'b0000000, 3'b100}: ctrl.aluOp = rvPkg::XOR;
					{7'b0000000, 3'b010}: ctrl.aluOp = rvPkg::SLT;
					default: ctrl = '0;
				endcase
			end
			rvPkg::OP_IMM: begin
				// only addi
				if (funct3 == 3'b000) begin
					ctrl.regWrite = 1'b1;
					ctrl.useImm = 1'b1;
					imm = immI;
				end
			end
			rvPkg::LOAD: begin
				if (funct3 == 3'b010) begin
					ctrl.regWrite = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.useImm = 1'b1;
					imm = immI;
				end
			end
			rvPkg::STORE: begin
				if (funct3 == 3'b010) begin
					ctrl.memWrite = 1'b1;
					ctrl.useImm = 1'b1;
					imm = immS;
				end
			end
			rvPkg::BRANCH: begin
				// beq only
				if (funct3 == 3'b000) begin
					ctrl.isBranch = 1'b1;
					ctrl.aluOp = rvPkg::SUB;
					imm = immB;
				end
			end
			rvPkg::JAL: begin
				ctrl.regWrite = 1'b1;
				ctrl.isJump = 1'b1;
				imm = immJ;
			end
			rvPkg::SYSTEM: begin
				if (instr == 32'h00100073) begin
					ctrl.isHalt = 1'b1;
				end
			end
			default: ctrl = '0;
		endcase
		// x0 stays zero
		if (rd == '0) begin
			ctrl.regWrite = 1'b0;
		end
	end

endmodule

// File: core/rvExecute.sv
module rvExecute (
	input rvPkg::ctrlT ctrl,
	input logic [rvPkg::PC_W-1:0] pcPlus4,
	input logic [rvPkg::XLEN-1:0] imm,
	input logic [rvPkg::REG_AW-1:0] rs1,
	input logic [rvPkg::REG_AW-1:0] rs2,
	input logic [rvPkg::XLEN-1:0] rd1,
	input logic [rvPkg::XLEN-1:0] rd2,
	input rvPkg::rfWriteT wbFwd,
	output logic [rvPkg::XLEN-1:0] aluResult,
	output logic [rvPkg::XLEN-1:0] storeData,
	output logic redirect,
	output logic [rvPkg::PC_W-1:0] target
);

	logic [rvPkg::XLEN-1:0] opA;
	logic [rvPkg::XLEN-1:0] opRs2;
	logic [rvPkg::XLEN-1:0] opB;
	logic [rvPkg::XLEN-1:0] aluOut;

	// bypass from the instruction in stage 4
	assign opA = (wbFwd.we && wbFwd.addr == rs1) ? wbFwd.data : rd1;
	assign opRs2 = (wbFwd.we && wbFwd.addr == rs2) ? wbFwd.data : rd2;
	assign opB = ctrl.useImm ? imm : opRs2;

	always_comb begin
		case (ctrl.aluOp)
			rvPkg::ADD: aluOut = opA + opB;
			rvPkg::SUB: aluOut = opA - opB;
			rvPkg::AND: aluOut = opA & opB;
			rvPkg::OR: aluOut = opA | opB;
			rvPkg::XOR: aluOut = opA ^ opB;
			rvPkg::SLT: aluOut = {{(rvPkg::XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			default: aluOut = '0;
		endcase
	end

	// jal links the return address
	assign aluResult = ctrl.isJump ? {{(rvPkg::XLEN-rvPkg::PC_W){1'b0}}, pcPlus4} : aluOut;
	assign storeData = opRs2;

	assign redirect = (ctrl.isBranch && opA == opRs2) || ctrl.isJump;
	// own pc plus offset
	assign target = pcPlus4 - rvPkg::PC_W'(4) + imm[rvPkg::PC_W-1:0];

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f all.f --top-module cpuSystemTb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "^PASS: all tests$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: verification/cpuSystemAssert_assert.sv
module cpuSystemAssert (
	input logic CLK,
	input logic RSTn,
	input logic halt,
	input rvPkg::rfWriteT rfWrite,
	input rvPkg::dMemReqT dMemReq
);
	timeunit 1ns;
	timeprecision 100ps;

	// halt is sticky until reset
	haltHolds: assert property (@(posedge CLK) $fell(halt) |-> $past(RSTn))
		else $error("halt fell outside reset");

	quietInReset: assert property (@(posedge CLK)
		RSTn && $past(RSTn) |-> !rfWrite.we && !dMemReq.wen)
		else $error("write strobe active during reset");

	noZeroWrite: assert property (@(posedge CLK) disable iff (RSTn)
		rfWrite.we |-> rfWrite.addr != '0)
		else $error("register x0 written");

endmodule

// File: verification/cpuSystemTb.sv
module cpuSystemTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_CYCLES = 5000;
	localparam logic [9:0] fnAdd = 10'h000;
	localparam logic [9:0] fnSub = 10'h100;
	localparam logic [9:0] fnAnd = 10'h007;
	localparam logic [9:0] fnOr = 10'h006;
	localparam logic [9:0] fnXor = 10'h004;
	localparam logic [9:0] fnSlt = 10'h002;

	logic CLK;
	logic RSTn;
	rvPkg::progWriteT progWrite;
	logic halt;
	logic [31:0] numInst;
	rvPkg::rfWriteT wbPort;

	logic [31:0] prog [$];
	rvPkg::rfWriteT expWrites [$];
	rvPkg::rfWriteT gotWrites [$];
	int expCount;
	int errors = 0;
	int cycles = 0;
	logic [31:0] seed = 32'd34313;

	cpuSystem dut_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.progWrite(progWrite),
		.halt(halt),
		.numInst(numInst),
		.wbPort(wbPort)
	);

	bind rvCore cpuSystemAssert assert_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.halt(halt),
		.rfWrite(rfWrite),
		.dMemReq(dMemReq)
	);

	always #10 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// sample mid-cycle where wbPort is settled
	always @(negedge CLK) begin
		if (!RSTn && wbPort.we) begin
			gotWrites.push_back(wbPort);
		end
	end

	function automatic logic [31:0] lcgNext();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic logic [31:0] rOp(logic [9:0] fn, logic [4:0] rd, logic [4:0] rs1,
			logic [4:0] rs2);
		return {fn[9:3], rs2, rs1, fn[2:0], rd, 7'h33};
	endfunction

	function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'h13};
	endfunction

	function automatic logic [31:0] lw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'h03};
	endfunction

	function automatic logic [31:0] sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] beq(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	task automatic emit(logic [31:0] word);
		prog.push_back(word);
	endtask

	// architectural reference, one instruction at a time
	task automatic isaModel();
		logic [31:0] regs [32];
		logic [31:0] dmem [int];
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		logic doWrite;
		int pc;
		int cur;
		expWrites.delete();
		expCount = 0;
		pc = 0;
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		while (pc / 4 < prog.size() && expCount < 200) begin
			ins = prog[pc / 4];
			a = regs[ins[19:15]];
			b = regs[ins[24:20]];
			cur = pc;
			pc = pc + 4;
			doWrite = 1'b0;
			res = '0;
			expCount++;
			if (ins == 32'h00100073) begin
				break;
			end
			case (ins[6:0])
				7'h33: begin
					doWrite = 1'b1;
					case ({ins[31:25], ins[14:12]})
						fnAdd: res = a + b;
						fnSub: res = a - b;
						fnAnd: res = a & b;
						fnOr: res = a | b;
						fnXor: res = a ^ b;
						fnSlt: res = {31'b0, $signed(a) < $signed(b)};
						default: doWrite = 1'b0;
					endcase
				end
				7'h13: begin
					doWrite = 1'b1;
					res = a + {{20{ins[31]}}, ins[31:20]};
				end
				7'h03: begin
					addr = a + {{20{ins[31]}}, ins[31:20]};
					res = dmem.exists(int'(addr[11:2])) ? dmem[int'(addr[11:2])] : '0;
					doWrite = 1'b1;
				end
				7'h23: begin
					addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					dmem[int'(addr[11:2])] = b;
				end
				7'h63: begin
					if (a == b) begin
						pc = cur + $signed({{19{ins[31]}}, ins[31], ins[7], ins[30:25],
							ins[11:8], 1'b0});
					end
				end
				7'h6f: begin
					doWrite = 1'b1;
					res = cur + 4;
					pc = cur + $signed({{11{ins[31]}}, ins[31], ins[19:12], ins[20],
						ins[30:21], 1'b0});
				end
				default: ;
			endcase
			if (doWrite && ins[11:7] != 5'd0) begin
				regs[ins[11:7]] = res;
				expWrites.push_back('{we: 1'b1, addr: ins[11:7], data: res});
			end
		end
	endtask

	// load under reset, run to halt, compare with the model
	task automatic runProgram(string name);
		isaModel();
		@(posedge CLK);
		RSTn <= 1'b1;
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge CLK);
			progWrite <= '{valid: 1'b1, addr: 10'(i), data: prog[i]};
		end
		@(posedge CLK);
		progWrite <= '0;
		repeat (16) @(posedge CLK);
		gotWrites.delete();
		RSTn <= 1'b0;
		@(negedge CLK);
		while (!halt) begin
			@(negedge CLK);
		end
		repeat (6) begin
			@(negedge CLK);
			assert (halt) else begin
				$display("%s: halt dropped after it was raised", name);
				errors++;
			end
		end
		assert (gotWrites.size() == expWrites.size()) else begin
			$display("FAILED %s wbPort count expected %h actual %h", name,
				expWrites.size(), gotWrites.size());
			errors++;
		end
		for (int i = 0; i < expWrites.size() && i < gotWrites.size(); i++) begin
			assert (gotWrites[i].addr == expWrites[i].addr) else begin
				$display("FAILED %s wbPort.addr[%0d] expected %h actual %h", name, i,
					expWrites[i].addr, gotWrites[i].addr);
				errors++;
			end
			assert (gotWrites[i].data == expWrites[i].data) else begin
				$display("FAILED %s wbPort.data[%0d] expected %h actual %h", name, i,
					expWrites[i].data, gotWrites[i].data);
				errors++;
			end
		end
		assert (numInst == expCount) else begin
			$display("FAILED %s numInst expected %h actual %h", name, expCount, numInst);
			errors++;
		end
	endtask

	task automatic checkNoWrite(logic [4:0] reg_);
		foreach (gotWrites[i]) begin
			assert (gotWrites[i].addr != reg_) else begin
				$display("unexpected write-back to x%0d on wbPort", reg_);
				errors++;
			end
		end
	endtask

	task automatic aluChainTest();
		prog.delete();
		emit(addi(1, 0, 12'(lcgNext() >> 20)));
		emit(addi(2, 0, 12'(lcgNext() >> 20)));
		emit(rOp(fnAdd, 3, 1, 2));
		emit(rOp(fnSub, 4, 3, 1));
		emit(rOp(fnAnd, 5, 4, 2));
		emit(rOp(fnOr, 6, 5, 3));
		emit(rOp(fnXor, 7, 6, 4));
		emit(rOp(fnSlt, 8, 7, 5));
		emit(rOp(fnSlt, 9, 2, 1));
		emit(addi(10, 9, 12'(lcgNext() >> 20)));
		emit(rOp(fnAdd, 11, 10, 10));
		emit(32'h00100073);
		runProgram("alu chain");
	endtask

	task automatic memoryTest();
		prog.delete();
		emit(addi(1, 0, 12'(lcgNext() >> 20)));
		emit(addi(2, 0, 12'(lcgNext() >> 20)));
		emit(rOp(fnAdd, 3, 1, 2));
		emit(addi(10, 0, 64));
		emit(sw(1, 10, 0));
		emit(sw(2, 10, 4));
		emit(sw(3, 10, -4));
		emit(lw(4, 10, 0));
		// load result used right away
		emit(rOp(fnAdd, 5, 4, 4));
		emit(lw(6, 10, 4));
		emit(lw(7, 10, -4));
		emit(rOp(fnSub, 8, 7, 6));
		emit(32'h00100073);
		runProgram("memory");
	endtask

	task automatic controlFlowTest();
		prog.delete();
		emit(addi(1, 0, 5));
		emit(addi(2, 0, 5));
		emit(beq(1, 2, 12));
		emit(addi(3, 0, 1));
		emit(addi(4, 0, 2));
		emit(addi(5, 0, 3));
		emit(beq(1, 5, 8));
		emit(addi(6, 0, 4));
		emit(jal(7, 12));
		emit(addi(8, 0, 9));
		emit(addi(9, 0, 9));
		emit(rOp(fnAdd, 10, 7, 1));
		emit(32'h00100073);
		runProgram("control flow");
		checkNoWrite(3);
		checkNoWrite(4);
		checkNoWrite(8);
		checkNoWrite(9);
	endtask

	task automatic zeroRegTest();
		prog.delete();
		emit(addi(0, 0, 123));
		emit(addi(1, 0, 5));
		emit(rOp(fnAdd, 0, 1, 1));
		emit(rOp(fnAdd, 2, 0, 1));
		emit(rOp(fnSub, 4, 0, 1));
		emit(32'h00100073);
		runProgram("register zero");
		checkNoWrite(0);
	endtask

	task automatic haltCountTest();
		prog.delete();
		emit(addi(1, 0, 1));
		emit(addi(2, 0, 2));
		emit(32'h00100073);
		emit(addi(3, 0, 3));
		emit(rOp(fnAdd, 4, 1, 2));
		emit(jal(5, -8));
		runProgram("halt and count");
	endtask

	initial begin
		CLK = 1'b0;
		RSTn = 1'b1;
		progWrite = '0;
		aluChainTest();
		memoryTest();
		controlFlowTest();
		zeroRegTest();
		haltCountTest();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: verilog/cpuSystem.sv
module cpuSystem (
	input logic CLK,
	input logic RSTn,
	input rvPkg::progWriteT progWrite,
	output logic halt,
	output logic [31:0] numInst,
	output rvPkg::rfWriteT wbPort
);

	logic [rvPkg::PC_W-1:0] iMemAddr;
	logic [rvPkg::XLEN-1:0] iMemData;
	rvPkg::dMemReqT dMemReq;
	logic [rvPkg::XLEN-1:0] dMemRdata;
	logic [rvPkg::REG_AW-1:0] rfRa1;
	logic [rvPkg::REG_AW-1:0] rfRa2;
	logic [rvPkg::XLEN-1:0] rfRd1;
	logic [rvPkg::XLEN-1:0] rfRd2;

	rvCore core_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.iMemAddr(iMemAddr),
		.iMemData(iMemData),
		.dMemReq(dMemReq),
		.dMemRdata(dMemRdata),
		.rfRa1(rfRa1),
		.rfRa2(rfRa2),
		.rfRd1(rfRd1),
		.rfRd2(rfRd2),
		.rfWrite(wbPort),
		.halt(halt),
		.numInst(numInst)
	);

	// write-back port doubles as the register file write
	regFile regFile_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.ra1(rfRa1),
		.ra2(rfRa2),
		.wr(wbPort),
		.rd1(rfRd1),
		.rd2(rfRd2)
	);

	instMem instMem_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.prog(progWrite),
		.addr(iMemAddr),
		.data(iMemData)
	);

	dataMem dataMem_i (
		.CLK(CLK),
		.req(dMemReq),
		.rdata(dMemRdata)
	);

endmodule

// File: verilog/dataMem.sv
module dataMem (
	input logic CLK,
	input rvPkg::dMemReqT req,
	output logic [rvPkg::XLEN-1:0] rdata
);

	logic [rvPkg::XLEN-1:0] mem [rvPkg::MEM_WORDS];

	always_ff @(posedge CLK) begin
		if (req.wen) begin
			mem[req.addr] <= req.wdata;
		end
	end

	// read is combinational so loads need no stall
	assign rdata = mem[req.addr];

endmodule

// File: verilog/instMem.sv
module instMem (
	input logic CLK,
	input logic RSTn,
	input rvPkg::progWriteT prog,
	input logic [rvPkg::PC_W-1:0] addr,
	output logic [rvPkg::XLEN-1:0] data
);

	logic [rvPkg::XLEN-1:0] mem [rvPkg::MEM_WORDS];

	// program load only while in reset
	always_ff @(posedge CLK) begin
		if (RSTn && prog.valid) begin
			mem[prog.addr] <= prog.data;
		end
	end

	// byte address to word index
	assign data = mem[addr[rvPkg::PC_W-1:2]];

endmodule

// File: verilog/regFile.sv
module regFile (
	input logic CLK,
	input logic RSTn,
	input logic [rvPkg::REG_AW-1:0] ra1,
	input logic [rvPkg::REG_AW-1:0] ra2,
	input rvPkg::rfWriteT wr,
	output logic [rvPkg::XLEN-1:0] rd1,
	output logic [rvPkg::XLEN-1:0] rd2
);

	logic [rvPkg::XLEN-1:0] regs [rvPkg::NUM_REGS];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < rvPkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.we && wr.addr != '0) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// same-cycle write is seen by readers
	assign rd1 = (wr.we && wr.addr == ra1 && ra1 != '0) ? wr.data : regs[ra1];
	assign rd2 = (wr.we && wr.addr == ra2 && ra2 != '0) ? wr.data : regs[ra2];

endmodule
